/* rtl/change_dispenser.sv */
/*
 * Change dispenser
 * Holds the amount still owed and offers the largest coin that fits.
 * Each accepted coin is subtracted; nothing is offered while loading.
 */
`timescale 1ns/1ns
`include "vend_consts.svh"

module change_dispenser (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 change_load,
    input  vend_pkg::money_t     change_amount,
    input  logic                 change_ready,
    output logic                 change_valid,
    output vend_pkg::coin_code_t change_code,
    output vend_pkg::money_t     change_left
);

    vend_pkg::money_t owed;
    vend_pkg::money_t coin_value;

    ////////////////////////////////////////////////////////////////////
    // Greedy coin pick
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        if (owed >= vend_pkg::money_t'(`VEND_COIN_VAL_6)) begin
            change_code = vend_pkg::coin_code_t'(6);
            coin_value  = vend_pkg::money_t'(`VEND_COIN_VAL_6);
        end else if (owed >= vend_pkg::money_t'(`VEND_COIN_VAL_5)) begin
            change_code = vend_pkg::coin_code_t'(5);
            coin_value  = vend_pkg::money_t'(`VEND_COIN_VAL_5);
        end else if (owed >= vend_pkg::money_t'(`VEND_COIN_VAL_4)) begin
            change_code = vend_pkg::coin_code_t'(4);
            coin_value  = vend_pkg::money_t'(`VEND_COIN_VAL_4);
        end else if (owed >= vend_pkg::money_t'(`VEND_COIN_VAL_3)) begin
            change_code = vend_pkg::coin_code_t'(3);
            coin_value  = vend_pkg::money_t'(`VEND_COIN_VAL_3);
        end else if (owed >= vend_pkg::money_t'(`VEND_COIN_VAL_2)) begin
            change_code = vend_pkg::coin_code_t'(2);
            coin_value  = vend_pkg::money_t'(`VEND_COIN_VAL_2);
        end else if (owed != '0) begin
            change_code = vend_pkg::coin_code_t'(1);
            coin_value  = vend_pkg::money_t'(`VEND_COIN_VAL_1);
        end else begin
            change_code = '0;                   // Nothing owed
            coin_value  = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Amount owed
    ////////////////////////////////////////////////////////////////////

    // Held off while the FSM keeps loading
    assign change_valid = (owed != '0) && !change_load;
    assign change_left  = owed;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owed <= '0;
        end else if (change_load) begin
            owed <= change_amount;
        end else if (change_valid && change_ready) begin
            owed <= owed - coin_value;
        end
    end

endmodule

/* rtl/credit_counter.sv */
/*
 * Credit counter
 * Adds the value of each accepted coin to the running credit.
 * Drives coin_ready while collecting and there is room for a 100.
 */
`timescale 1ns/1ns
`include "vend_consts.svh"

module credit_counter (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 coin_valid,
    input  vend_pkg::coin_code_t coin_code,
    input  logic                 coin_enable,
    input  logic                 credit_clear,
    output logic                 coin_ready,
    output vend_pkg::money_t     credit
);

    vend_pkg::money_t coin_value;
    logic             headroom;

    // Codes 0 and 7 are worth nothing
    always_comb begin
        case (coin_code)
            3'd1:    coin_value = vend_pkg::money_t'(`VEND_COIN_VAL_1);
            3'd2:    coin_value = vend_pkg::money_t'(`VEND_COIN_VAL_2);
            3'd3:    coin_value = vend_pkg::money_t'(`VEND_COIN_VAL_3);
            3'd4:    coin_value = vend_pkg::money_t'(`VEND_COIN_VAL_4);
            3'd5:    coin_value = vend_pkg::money_t'(`VEND_COIN_VAL_5);
            3'd6:    coin_value = vend_pkg::money_t'(`VEND_COIN_VAL_6);
            default: coin_value = '0;
        endcase
    end

    // Largest coin must still fit in the counter
    assign headroom   = (32'(credit) + `VEND_COIN_VAL_6) < (1 << `VEND_MONEY_W);
    assign coin_ready = coin_enable && headroom;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit <= '0;
        end else if (credit_clear) begin
            credit <= '0;                       // Purchase wins over a coin
        end else if (coin_valid && coin_ready) begin
            credit <= credit + coin_value;
        end
    end

endmodule

/* rtl/selection_decoder.sv */
/*
 * Selection decoder
 * Maps the row and column keys to an item number and the row price.
 * The lowest pressed row and column win.
 */
`timescale 1ns/1ns
`include "vend_consts.svh"

module selection_decoder (
    input  logic [`VEND_ROWS-1:0] row_keys,
    input  logic [`VEND_COLS-1:0] col_keys,
    output logic                  key_hit,
    output vend_pkg::item_code_t  item_code,
    output vend_pkg::money_t      item_price
);

    logic [1:0] row_idx;
    logic [2:0] col_idx;

    assign key_hit = (|row_keys) && (|col_keys);

    // Lowest set bit wins
    always_comb begin
        row_idx = '0;
        for (int i = `VEND_ROWS - 1; i >= 0; i--) begin
            if (row_keys[i]) row_idx = 2'(i);
        end
    end

    always_comb begin
        col_idx = '0;
        for (int j = `VEND_COLS - 1; j >= 0; j--) begin
            if (col_keys[j]) col_idx = 3'(j);
        end
    end

    always_comb begin
        if (key_hit) begin
            item_code = vend_pkg::item_code_t'(row_idx * `VEND_COLS + col_idx + 1);
        end else begin
            item_code = '0;
        end
    end

    // One price per row
    always_comb begin
        case (row_idx)
            2'd0:    item_price = vend_pkg::money_t'(`VEND_PRICE_A);
            2'd1:    item_price = vend_pkg::money_t'(`VEND_PRICE_B);
            2'd2:    item_price = vend_pkg::money_t'(`VEND_PRICE_C);
            default: item_price = vend_pkg::money_t'(`VEND_PRICE_D);
        endcase
    end

endmodule

/* rtl/vend_consts.svh */
/*
 * Vending machine constants
 * Widths, key counts, row prices and coin values in cents
 */
`ifndef VEND_CONSTS_SVH
`define VEND_CONSTS_SVH

// Datapath widths
`define VEND_MONEY_W 10
`define VEND_COIN_W  3
`define VEND_ITEM_W  5

// Keypad layout
`define VEND_ROWS 4
`define VEND_COLS 5

// Row prices in cents
`define VEND_PRICE_A 100
`define VEND_PRICE_B 125
`define VEND_PRICE_C 150
`define VEND_PRICE_D 175

// Coin codes 1 to 6, same coding in and out
`define VEND_COIN_VAL_1 1
`define VEND_COIN_VAL_2 5
`define VEND_COIN_VAL_3 10
`define VEND_COIN_VAL_4 25
`define VEND_COIN_VAL_5 50
`define VEND_COIN_VAL_6 100

`endif

/* rtl/vend_fsm.sv */
/*
 * Vending controller FSM
 * Collects credit, checks it against the chosen row price, holds the
 * vend request until the food sensor fires, then waits out the change.
 */
`timescale 1ns/1ns

module vend_fsm (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 key_hit,
    input  vend_pkg::item_code_t item_code,
    input  vend_pkg::money_t     item_price,
    input  vend_pkg::money_t     credit,
    input  vend_pkg::money_t     change_left,
    input  logic                 food_dispensed,
    output logic                 coin_enable,
    output logic                 credit_clear,
    output logic                 change_load,
    output vend_pkg::money_t     change_amount,
    output logic                 vend_valid,
    output vend_pkg::item_code_t food_selection,
    output vend_pkg::money_t     display
);

    vend_pkg::vend_state_t state;
    vend_pkg::vend_state_t state_next;
    logic                  buy;

    // Selection with enough credit
    assign buy = (state == vend_pkg::collecting) && key_hit && (credit >= item_price);

    ////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            vend_pkg::collecting: begin
                if (buy) state_next = vend_pkg::vending;
            end
            vend_pkg::vending: begin
                if (food_dispensed) state_next = vend_pkg::paying_change;
            end
            vend_pkg::paying_change: begin
                if (change_left == '0) state_next = vend_pkg::collecting;
            end
            default: state_next = vend_pkg::collecting;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= vend_pkg::collecting;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Vend request
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vend_valid     <= 1'b0;
            food_selection <= '0;
        end else if (buy) begin
            vend_valid     <= 1'b1;
            food_selection <= item_code;
        end else if (state == vend_pkg::vending && food_dispensed) begin
            vend_valid     <= 1'b0;             // Item has dropped
            food_selection <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Credit and change control
    ////////////////////////////////////////////////////////////////////

    // No coins taken in the cycle that spends the credit
    assign coin_enable  = (state == vend_pkg::collecting) && !buy;
    assign credit_clear = buy;

    // Change amount is held in the dispenser until the food drops
    assign change_load   = buy || (state == vend_pkg::vending);
    assign change_amount = buy ? credit - item_price : change_left;

    assign display = (state == vend_pkg::collecting) ? credit : change_left;

endmodule

/* rtl/vend_pkg.sv */
/*
 * Vending machine types
 * Money, coin and item widths plus the controller states
 */
`include "vend_consts.svh"

package vend_pkg;

    typedef logic [`VEND_MONEY_W-1:0] money_t;     // Cents
    typedef logic [`VEND_COIN_W-1:0]  coin_code_t; // 0 is no coin
    typedef logic [`VEND_ITEM_W-1:0]  item_code_t; // 1 to 20, 0 is none

    typedef enum logic [1:0] {
        collecting,
        vending,
        paying_change
    } vend_state_t;

endpackage

/* rtl/vending_machine.sv */
/*
 * Vending machine top
 * Keypad decoder, credit counter, controller FSM and change dispenser.
 */
`timescale 1ns/1ns
`include "vend_consts.svh"

module vending_machine (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  coin_valid,
    input  vend_pkg::coin_code_t  coin_code,
    output logic                  coin_ready,
    input  logic [`VEND_ROWS-1:0] row_keys,
    input  logic [`VEND_COLS-1:0] col_keys,
    output logic                  vend_valid,
    output vend_pkg::item_code_t  food_selection,
    input  logic                  food_dispensed,
    output logic                  change_valid,
    output vend_pkg::coin_code_t  change_code,
    input  logic                  change_ready,
    output vend_pkg::money_t      display
);

    logic                 key_hit;
    vend_pkg::item_code_t item_code;
    vend_pkg::money_t     item_price;
    vend_pkg::money_t     credit;
    logic                 coin_enable;
    logic                 credit_clear;
    logic                 change_load;
    vend_pkg::money_t     change_amount;
    vend_pkg::money_t     change_left;

    selection_decoder u_decoder (
        .row_keys   (row_keys),
        .col_keys   (col_keys),
        .key_hit    (key_hit),
        .item_code  (item_code),
        .item_price (item_price)
    );

    credit_counter u_credit (
        .clock        (clock),
        .reset        (reset),
        .coin_valid   (coin_valid),
        .coin_code    (coin_code),
        .coin_enable  (coin_enable),
        .credit_clear (credit_clear),
        .coin_ready   (coin_ready),
        .credit       (credit)
    );

    vend_fsm u_fsm (
        .clock (clock), .reset (reset),
        .key_hit (key_hit), .item_code (item_code), .item_price (item_price),
        .credit (credit), .change_left (change_left), .food_dispensed (food_dispensed),
        .coin_enable (coin_enable), .credit_clear (credit_clear),
        .change_load (change_load), .change_amount (change_amount),
        .vend_valid (vend_valid), .food_selection (food_selection), .display (display)
    );

    change_dispenser u_change (
        .clock         (clock),
        .reset         (reset),
        .change_load   (change_load),
        .change_amount (change_amount),
        .change_ready  (change_ready),
        .change_valid  (change_valid),
        .change_code   (change_code),
        .change_left   (change_left)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the vending machine regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_vending_machine -Mdir obj_dir -o tb_vending_machine -f sim.f

./obj_dir/tb_vending_machine > sim.log
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    echo "simulation finished without errors"
else
    echo "simulation reported errors, see sim.log"
    exit 1
fi

/* sim.f */
+incdir+rtl
+incdir+verif
rtl/vend_pkg.sv
rtl/selection_decoder.sv
rtl/credit_counter.sv
rtl/change_dispenser.sv
rtl/vend_fsm.sv
rtl/vending_machine.sv
verif/tb_vending_machine.sv

/* verif/vend_model.svh */
/*
 * Reference model for the vending machine testbench
 * Coin values, item numbering, row prices, coin headroom and greedy change
 */
`ifndef VEND_MODEL_SVH
`define VEND_MODEL_SVH

`include "vend_consts.svh"

// Codes 0 and 7 are worth nothing
function automatic vend_pkg::money_t coin_cents(input vend_pkg::coin_code_t code);
    int values [8];
    values = '{0, `VEND_COIN_VAL_1, `VEND_COIN_VAL_2, `VEND_COIN_VAL_3,
               `VEND_COIN_VAL_4, `VEND_COIN_VAL_5, `VEND_COIN_VAL_6, 0};
    return vend_pkg::money_t'(values[code]);
endfunction

// Items numbered row by row from 1, 0 when no full selection
function automatic vend_pkg::item_code_t item_number(input logic [`VEND_ROWS-1:0] rows,
                                                     input logic [`VEND_COLS-1:0] cols);
    int row_pick;
    int col_pick;
    row_pick = -1;
    col_pick = -1;
    for (int r = 0; r < `VEND_ROWS; r++) begin
        if (rows[r] && row_pick < 0) row_pick = r;
    end
    for (int c = 0; c < `VEND_COLS; c++) begin
        if (cols[c] && col_pick < 0) col_pick = c;
    end
    if (row_pick < 0 || col_pick < 0) return '0;
    return vend_pkg::item_code_t'(row_pick * `VEND_COLS + col_pick + 1);
endfunction

function automatic vend_pkg::money_t row_price(input logic [`VEND_ROWS-1:0] rows);
    int prices [`VEND_ROWS];
    prices = '{`VEND_PRICE_A, `VEND_PRICE_B, `VEND_PRICE_C, `VEND_PRICE_D};
    for (int r = 0; r < `VEND_ROWS; r++) begin
        if (rows[r]) return vend_pkg::money_t'(prices[r]);
    end
    return '0;
endfunction

// A 100 must still fit under the counter limit
function automatic bit has_room(input vend_pkg::money_t credit);
    return (32'(credit) + `VEND_COIN_VAL_6) <= ((1 << `VEND_MONEY_W) - 1);
endfunction

// Largest coin not above the amount owed
function automatic vend_pkg::coin_code_t greedy_coin(input vend_pkg::money_t owed);
    for (int c = 6; c >= 1; c--) begin
        if (coin_cents(vend_pkg::coin_code_t'(c)) <= owed) return vend_pkg::coin_code_t'(c);
    end
    return '0;
endfunction

function automatic int greedy_count(input vend_pkg::money_t amount);
    vend_pkg::money_t left;
    int               count;
    left  = amount;
    count = 0;
    while (left != '0) begin
        left = left - coin_cents(greedy_coin(left));
        count++;
    end
    return count;
endfunction

`endif

/* verif/tb_vending_machine.sv */
/*
 * Vending machine testbench
 * Random coins, key presses, food sensor delays and change back-pressure,
 * checked against the reference model, with a watchdog and a summary.
 */
`timescale 1ns/1ns
`include "vend_consts.svh"

module tb_vending_machine;

    `include "vend_model.svh"

    localparam int     clock_period = 40;
    localparam int     reset_cycles = 16;
    localparam int     coin_cycles  = 150;
    localparam int     purchases    = 24;
    localparam int     worst_cycles = 200;     // Per transaction, stalls included
    localparam longint watchdog_ns  =
        longint'(reset_cycles + coin_cycles + purchases) * worst_cycles * clock_period;

    logic                  clock;
    logic                  reset;
    logic                  coin_valid;
    vend_pkg::coin_code_t  coin_code;
    logic                  coin_ready;
    logic [`VEND_ROWS-1:0] row_keys;
    logic [`VEND_COLS-1:0] col_keys;
    logic                  vend_valid;
    vend_pkg::item_code_t  food_selection;
    logic                  food_dispensed;
    logic                  change_valid;
    vend_pkg::coin_code_t  change_code;
    logic                  change_ready;
    vend_pkg::money_t      display;

    int                   seed;
    int                   tests;
    int                   checks;
    int                   errors;
    int                   checks_mark;
    int                   errors_mark;
    string                outcome;
    vend_pkg::money_t     model_credit;
    logic                 seen_coin_ready;     // Sampled mid-cycle
    logic                 seen_change_valid;
    vend_pkg::coin_code_t seen_change_code;

    vending_machine dut0 (
        .clock (clock), .reset (reset),
        .coin_valid (coin_valid), .coin_code (coin_code), .coin_ready (coin_ready),
        .row_keys (row_keys), .col_keys (col_keys),
        .vend_valid (vend_valid), .food_selection (food_selection),
        .food_dispensed (food_dispensed),
        .change_valid (change_valid), .change_code (change_code),
        .change_ready (change_ready), .display (display)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("error %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Sample handshakes before the edge, land 2 ns after it
    task automatic advance();
        #(clock_period / 2);
        seen_coin_ready   = coin_ready;
        seen_change_valid = change_valid;
        seen_change_code  = change_code;
        @(posedge clock);
        #2;
    endtask

    task automatic begin_test();
        checks_mark = checks;
        errors_mark = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequences
    //////////////////////////////////////////////////////////////////////

    task automatic insert_coins(input int cycles);
        logic [31:0] r;
        for (int n = 0; n < cycles; n++) begin
            r          = next_random();
            coin_valid = r[0];
            coin_code  = r[3:1];
            advance();
            check_value("coin_ready", 32'(seen_coin_ready), 32'(has_room(model_credit)));
            if (coin_valid && seen_coin_ready) begin
                model_credit = model_credit + coin_cents(coin_code);
            end
            check_value("display", 32'(display), 32'(model_credit));
        end
        coin_valid = 1'b0;
    endtask

    task automatic collect_change(input vend_pkg::money_t owed);
        logic [31:0]          r;
        vend_pkg::money_t     remaining;
        vend_pkg::money_t     paid;
        vend_pkg::coin_code_t held_code;
        logic                 stalled;
        int                   coins;
        remaining = owed;
        paid      = '0;
        held_code = '0;
        stalled   = 1'b0;
        coins     = 0;
        while (remaining != '0) begin
            check_value("display", 32'(display), 32'(remaining));
            r            = next_random();
            change_ready = r[0];
            advance();
            check_value("change_valid", 32'(seen_change_valid), 32'd1);
            if (stalled) check_value("change_code", 32'(seen_change_code), 32'(held_code));
            if (!seen_change_valid) begin
                remaining = '0;                 // Payout lost, stop here
            end else if (change_ready) begin
                check_value("change_code", 32'(seen_change_code), 32'(greedy_coin(remaining)));
                paid      = paid + coin_cents(seen_change_code);
                remaining = remaining - coin_cents(greedy_coin(remaining));
                stalled   = 1'b0;
                coins++;
            end else begin
                stalled   = 1'b1;
                held_code = seen_change_code;
            end
        end
        change_ready = 1'b0;
        check_value("change coins", 32'(coins), 32'(greedy_count(owed)));
        check_value("change sum", 32'(paid), 32'(owed));
        check_value("change_valid", 32'(change_valid), 32'd0);
        advance();
        check_value("display", 32'(display), 32'd0);
        check_value("coin_ready", 32'(coin_ready), 32'd1);
        outcome = $sformatf("%s, %0d change coins", outcome, coins);
    endtask

    task automatic run_purchase();
        logic [31:0]          r;
        vend_pkg::money_t     price;
        vend_pkg::item_code_t item;
        vend_pkg::money_t     owed;
        int                   delay;
        r = next_random();
        insert_coins(4 + int'(r[3:0]));
        r        = next_random();
        row_keys = r[3:0];
        col_keys = r[8:4];
        item     = item_number(row_keys, col_keys);
        price    = row_price(row_keys);
        advance();
        row_keys = '0;
        col_keys = '0;
        if (item == '0 || model_credit < price) begin
            check_value("vend_valid", 32'(vend_valid), 32'd0);
            check_value("display", 32'(display), 32'(model_credit));
            outcome = $sformatf("refused at %0d cents", model_credit);
        end else begin
            owed         = model_credit - price;
            model_credit = '0;
            check_value("vend_valid", 32'(vend_valid), 32'd1);
            check_value("food_selection", 32'(food_selection), 32'(item));
            check_value("display", 32'(display), 32'(owed));
            r     = next_random();
            delay = int'(r[3:0]);
            for (int n = 0; n < delay; n++) begin
                r          = next_random();
                coin_valid = r[0];                // Must be refused while vending
                coin_code  = r[3:1];
                advance();
                check_value("coin_ready", 32'(seen_coin_ready), 32'd0);
                check_value("vend_valid", 32'(vend_valid), 32'd1);
                check_value("food_selection", 32'(food_selection), 32'(item));
                check_value("change_valid", 32'(change_valid), 32'd0);
            end
            coin_valid     = 1'b0;
            food_dispensed = 1'b1;
            advance();
            food_dispensed = 1'b0;
            check_value("vend_valid", 32'(vend_valid), 32'd0);
            outcome = $sformatf("bought item %0d", item);
            collect_change(owed);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed           = 32'h93114ad6;
        tests          = 0;
        checks         = 0;
        errors         = 0;
        model_credit   = '0;
        reset          = 1'b1;
        coin_valid     = 1'b0;
        coin_code      = '0;
        row_keys       = '0;
        col_keys       = '0;
        food_dispensed = 1'b0;
        change_ready   = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #2;
        reset = 1'b0;

        begin_test();
        check_value("display", 32'(display), 32'd0);
        check_value("vend_valid", 32'(vend_valid), 32'd0);
        check_value("change_valid", 32'(change_valid), 32'd0);
        check_value("coin_ready", 32'(coin_ready), 32'd1);
        end_test("reset");

        begin_test();
        insert_coins(coin_cycles);              // Runs into the headroom limit
        end_test("coin counting");

        for (int i = 0; i < purchases; i++) begin
            begin_test();
            run_purchase();
            end_test($sformatf("purchase %0d, %s", i, outcome));
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
